// ==== source/iq_macros.svh ====
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// queue geometry.
`define IQ_DEPTH 16
`define IQ_INS_COUNT 4  // decode width per cycle.
`define IQ_EXT_COUNT 4  // one head slot per issue lane.

// datapath widths.
`define IQ_DATA_W 8
`define IQ_ROB_W 4

// each stream keeps its own retire counter of this width.
`define IQ_CNT_W 16

`endif

// ==== source/iq_pkg.sv ====
`include "iq_macros.svh"

package iq_pkg;

  // lane operations. All results wrap at the operand width.
  typedef enum logic [1:0] {
    op_add  = 2'b00,
    op_sub  = 2'b01,
    op_xor  = 2'b10,
    op_pass = 2'b11
  } iq_op_e;

  // retire register occupancy.
  typedef enum logic [1:0] {
    st_idle    = 2'b00,
    st_present = 2'b01,
    st_hold    = 2'b10
  } collect_state_e;

  typedef struct packed {
    logic                  stream;
    logic [`IQ_ROB_W-1:0]  rob_slot;
    iq_op_e                op;
    logic [`IQ_DATA_W-1:0] operand_a;
    logic [`IQ_DATA_W-1:0] operand_b;
  } iq_entry_t;

endpackage

// ==== source/inst_queue.sv ====
`timescale 1ns/1ns
`include "iq_macros.svh"

module inst_queue import iq_pkg::*; #(
  parameter int DEPTH = `IQ_DEPTH
) (
  input  logic                           clock,
  input  logic                           reset_n,
  input  logic                           ins_enable_i,
  input  logic [$clog2(`IQ_INS_COUNT)-1:0] ins_count_i,
  input  iq_entry_t                      ins_entries_i [`IQ_INS_COUNT],
  input  logic                           advance_i,
  input  logic                           flush_i,
  input  logic                           flush_stream_i,
  output iq_entry_t                      head_entry_o [`IQ_EXT_COUNT],
  output logic [`IQ_EXT_COUNT-1:0]       head_valid_o,
  output logic                           full_o,
  output logic                           empty_o,
  output logic [$clog2(DEPTH):0]         used_count_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int INS_W = $clog2(`IQ_INS_COUNT);

  iq_entry_t        ring_q [DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [PTR_W:0]   used_q;

  logic             ins_ok;
  logic [PTR_W:0]   ext_num;
  logic [PTR_W:0]   ins_num;
  logic [PTR_W:0]   drop_num;
  logic [PTR_W:0]   used_after_ext;
  logic [PTR_W:0]   used_after_ins;
  logic             flush_run;
  logic [PTR_W:0]   ins_off;
  logic [PTR_W-1:0] walk_idx;
  logic             walk_stream;
  logic [PTR_W-1:0] wr_idx [`IQ_INS_COUNT];
  logic [PTR_W-1:0] rd_idx [`IQ_EXT_COUNT];

  ////////////////////
  // head window
  ////////////////////

  always_comb begin
    for (int i = 0; i < `IQ_EXT_COUNT; i++) begin
      rd_idx[i]       = head_q + PTR_W'(i);
      head_entry_o[i] = ring_q[rd_idx[i]];
      head_valid_o[i] = (used_q > i);  // slot i exists only past i entries.
    end
  end

  assign full_o       = (used_q > (DEPTH - `IQ_INS_COUNT));
  assign empty_o      = (used_q == '0);
  assign used_count_o = used_q;

  ////////////////////
  // next occupancy
  ////////////////////

  always_comb begin
    ext_num = '0;
    for (int i = 0; i < `IQ_EXT_COUNT; i++) begin
      if (advance_i && head_valid_o[i]) begin
        ext_num = ext_num + 1'b1;
      end
    end
    used_after_ext = used_q - ext_num;

    ins_ok         = ins_enable_i & ~full_o;  // an insert seen while full is lost.
    ins_num        = ins_ok ? ((PTR_W+1)'(ins_count_i) + 1'b1) : '0;
    used_after_ins = used_after_ext + ins_num;

    // the flush looks at the queue as it stands after extract and insert.
    // Entries past the old occupancy come straight from the insert port.
    drop_num    = '0;
    flush_run   = flush_i;
    ins_off     = '0;
    walk_idx    = '0;
    walk_stream = 1'b0;
    for (int k = 0; k < DEPTH; k++) begin
      walk_idx = head_q + ext_num[PTR_W-1:0] + PTR_W'(k);
      ins_off  = (PTR_W+1)'(k) - used_after_ext;
      if ((PTR_W+1)'(k) < used_after_ext) begin
        walk_stream = ring_q[walk_idx].stream;
      end else begin
        walk_stream = ins_entries_i[ins_off[INS_W-1:0]].stream;
      end
      if (flush_run && ((PTR_W+1)'(k) < used_after_ins) && (walk_stream == flush_stream_i)) begin
        drop_num = drop_num + 1'b1;
      end else begin
        flush_run = 1'b0;  // the run ends at the first other stream.
      end
    end

    for (int j = 0; j < `IQ_INS_COUNT; j++) begin
      wr_idx[j] = tail_q + PTR_W'(j);
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      head_q <= '0;
      tail_q <= '0;
      used_q <= '0;
    end else begin
      head_q <= head_q + ext_num[PTR_W-1:0] + drop_num[PTR_W-1:0];
      tail_q <= tail_q + ins_num[PTR_W-1:0];
      used_q <= used_after_ins - drop_num;
    end
  end

  // ring storage.
  always_ff @(posedge clock) begin
    for (int j = 0; j < `IQ_INS_COUNT; j++) begin
      if (ins_ok && (j <= ins_count_i)) begin
        ring_q[wr_idx[j]] <= ins_entries_i[j];
      end
    end
  end

endmodule

// ==== source/issue_lane.sv ====
`timescale 1ns/1ns
`include "iq_macros.svh"

module issue_lane import iq_pkg::*; (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  advance_i,
  input  iq_entry_t             entry_i,
  input  logic                  entry_valid_i,
  output logic                  valid_o,
  output logic                  stream_o,
  output logic [`IQ_ROB_W-1:0]  rob_slot_o,
  output logic [`IQ_DATA_W-1:0] result_o
);

  logic [`IQ_DATA_W-1:0] alu_result;

  ////////////////////
  // alu
  ////////////////////

  always_comb begin
    case (entry_i.op)
      op_add:  alu_result = entry_i.operand_a + entry_i.operand_b;
      op_sub:  alu_result = entry_i.operand_a - entry_i.operand_b;
      op_xor:  alu_result = entry_i.operand_a ^ entry_i.operand_b;
      op_pass: alu_result = entry_i.operand_a;
      default: alu_result = entry_i.operand_a;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_o <= 1'b0;
    end else if (advance_i) begin
      valid_o <= entry_valid_i;
    end
  end

  // result and tags move with the valid flag.
  always_ff @(posedge clock) begin
    if (advance_i) begin
      stream_o   <= entry_i.stream;
      rob_slot_o <= entry_i.rob_slot;
      result_o   <= alu_result;
    end
  end

endmodule

// ==== source/retire_collector.sv ====
`timescale 1ns/1ns
`include "iq_macros.svh"

module retire_collector import iq_pkg::*; (
  input  logic                     clock,
  input  logic                     reset_n,
  input  logic [`IQ_EXT_COUNT-1:0] lane_valid_i,
  input  logic [`IQ_EXT_COUNT-1:0] lane_stream_i,
  input  logic [`IQ_ROB_W-1:0]     lane_rob_slot_i [`IQ_EXT_COUNT],
  input  logic [`IQ_DATA_W-1:0]    lane_result_i [`IQ_EXT_COUNT],
  input  logic                     flush_i,
  input  logic                     flush_stream_i,
  input  logic                     retire_ready_i,
  output logic                     advance_o,
  output logic                     retire_valid_o,
  output logic [`IQ_EXT_COUNT-1:0] retire_slot_valid_o,
  output logic [`IQ_EXT_COUNT-1:0] retire_stream_o,
  output logic [`IQ_ROB_W-1:0]     retire_rob_slot_o [`IQ_EXT_COUNT],
  output logic [`IQ_DATA_W-1:0]    retire_result_o [`IQ_EXT_COUNT],
  output logic [`IQ_CNT_W-1:0]     retire_count_o [2]
);

  localparam int POP_W = $clog2(`IQ_EXT_COUNT) + 1;

  collect_state_e           state_q;
  collect_state_e           state_d;
  logic [`IQ_EXT_COUNT-1:0] keep;
  logic                     accept;
  logic [POP_W-1:0]         pop_s0;
  logic [POP_W-1:0]         pop_s1;

  assign retire_valid_o = (state_q != st_idle);
  assign accept         = retire_valid_o & retire_ready_i;
  assign advance_o      = (state_q == st_idle) | accept;  // the single stall source.

  // results of the flushed stream die as they enter the bundle.
  assign keep = lane_valid_i & ~({`IQ_EXT_COUNT{flush_i}} &
                                 ~(lane_stream_i ^ {`IQ_EXT_COUNT{flush_stream_i}}));

  ////////////////////
  // bundle fsm
  ////////////////////

  always_comb begin
    if (advance_o) begin
      state_d = (|keep) ? st_present : st_idle;
    end else begin
      state_d = st_hold;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state_q             <= st_idle;
      retire_slot_valid_o <= '0;
    end else begin
      state_q <= state_d;
      if (advance_o) begin
        retire_slot_valid_o <= keep;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (advance_o) begin
      retire_stream_o   <= lane_stream_i;
      retire_rob_slot_o <= lane_rob_slot_i;
      retire_result_o   <= lane_result_i;
    end
  end

  ////////////////////
  // retire counters
  ////////////////////

  always_comb begin
    pop_s0 = '0;
    pop_s1 = '0;
    for (int i = 0; i < `IQ_EXT_COUNT; i++) begin
      if (retire_slot_valid_o[i] && !retire_stream_o[i]) pop_s0 = pop_s0 + 1'b1;
      if (retire_slot_valid_o[i] && retire_stream_o[i]) pop_s1 = pop_s1 + 1'b1;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      retire_count_o[0] <= '0;
      retire_count_o[1] <= '0;
    end else if (accept) begin
      retire_count_o[0] <= retire_count_o[0] + pop_s0;
      retire_count_o[1] <= retire_count_o[1] + pop_s1;
    end
  end

endmodule

// ==== source/iq_subsystem.sv ====
`timescale 1ns/1ns
`include "iq_macros.svh"

module iq_subsystem import iq_pkg::*; (
  input  logic                             clock,
  input  logic                             reset_n,
  input  logic                             ins_enable_i,
  input  logic [$clog2(`IQ_INS_COUNT)-1:0] ins_count_i,
  input  iq_entry_t                        ins_entries_i [`IQ_INS_COUNT],
  input  logic                             flush_i,
  input  logic                             flush_stream_i,
  input  logic                             retire_ready_i,
  output logic                             full_o,
  output logic                             empty_o,
  output logic [$clog2(`IQ_DEPTH):0]       used_count_o,
  output logic                             retire_valid_o,
  output logic [`IQ_EXT_COUNT-1:0]         retire_slot_valid_o,
  output logic [`IQ_EXT_COUNT-1:0]         retire_stream_o,
  output logic [`IQ_ROB_W-1:0]             retire_rob_slot_o [`IQ_EXT_COUNT],
  output logic [`IQ_DATA_W-1:0]            retire_result_o [`IQ_EXT_COUNT],
  output logic [`IQ_CNT_W-1:0]             retire_count_o [2]
);

  iq_entry_t                head_entry [`IQ_EXT_COUNT];
  logic [`IQ_EXT_COUNT-1:0] head_valid;
  logic                     advance;
  logic [`IQ_EXT_COUNT-1:0] lane_valid;
  logic [`IQ_EXT_COUNT-1:0] lane_stream;
  logic [`IQ_ROB_W-1:0]     lane_rob_slot [`IQ_EXT_COUNT];
  logic [`IQ_DATA_W-1:0]    lane_result [`IQ_EXT_COUNT];

  inst_queue #(
    .DEPTH(`IQ_DEPTH)
  ) queue0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .ins_enable_i  (ins_enable_i),
    .ins_count_i   (ins_count_i),
    .ins_entries_i (ins_entries_i),
    .advance_i     (advance),
    .flush_i       (flush_i),
    .flush_stream_i(flush_stream_i),
    .head_entry_o  (head_entry),
    .head_valid_o  (head_valid),
    .full_o        (full_o),
    .empty_o       (empty_o),
    .used_count_o  (used_count_o)
  );

  // lane i always takes head slot i, which keeps program order across the bundle.
  for (genvar i = 0; i < `IQ_EXT_COUNT; i++) begin : lane_gen
    issue_lane lane0 (
      .clock        (clock),
      .reset_n      (reset_n),
      .advance_i    (advance),
      .entry_i      (head_entry[i]),
      .entry_valid_i(head_valid[i]),
      .valid_o      (lane_valid[i]),
      .stream_o     (lane_stream[i]),
      .rob_slot_o   (lane_rob_slot[i]),
      .result_o     (lane_result[i])
    );
  end

  retire_collector collect0 (
    .clock              (clock),
    .reset_n            (reset_n),
    .lane_valid_i       (lane_valid),
    .lane_stream_i      (lane_stream),
    .lane_rob_slot_i    (lane_rob_slot),
    .lane_result_i      (lane_result),
    .flush_i            (flush_i),
    .flush_stream_i     (flush_stream_i),
    .retire_ready_i     (retire_ready_i),
    .advance_o          (advance),
    .retire_valid_o     (retire_valid_o),
    .retire_slot_valid_o(retire_slot_valid_o),
    .retire_stream_o    (retire_stream_o),
    .retire_rob_slot_o  (retire_rob_slot_o),
    .retire_result_o    (retire_result_o),
    .retire_count_o     (retire_count_o)
  );

endmodule

// ==== verification/iq_tb.sv ====
`timescale 1ns/1ns
`include "iq_macros.svh"

module iq_tb import iq_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_CYCLES  = 80;
  localparam int DRAIN_LIMIT  = 100;
  localparam int MARGIN       = 50;
  // reset, single insert, random, full and flush tests in that order.
  localparam int TEST_BUDGET  = (RESET_CYCLES + 2) + (20 + DRAIN_LIMIT)
                                + (RAND_CYCLES + DRAIN_LIMIT)
                                + (20 + DRAIN_LIMIT) + (10 + DRAIN_LIMIT);

  logic                             clock = 1'b0;
  logic                             reset_n;
  logic                             ins_enable_i;
  logic [$clog2(`IQ_INS_COUNT)-1:0] ins_count_i;
  iq_entry_t                        ins_entries_i [`IQ_INS_COUNT];
  logic                             flush_i;
  logic                             flush_stream_i;
  logic                             retire_ready_i;
  logic                             full_o;
  logic                             empty_o;
  logic [$clog2(`IQ_DEPTH):0]       used_count_o;
  logic                             retire_valid_o;
  logic [`IQ_EXT_COUNT-1:0]         retire_slot_valid_o;
  logic [`IQ_EXT_COUNT-1:0]         retire_stream_o;
  logic [`IQ_ROB_W-1:0]             retire_rob_slot_o [`IQ_EXT_COUNT];
  logic [`IQ_DATA_W-1:0]            retire_result_o [`IQ_EXT_COUNT];
  logic [`IQ_CNT_W-1:0]             retire_count_o [2];

  iq_entry_t            stage [`IQ_INS_COUNT];
  iq_entry_t            expect_q [$];  // expected retirements in program order.
  logic [31:0]          lcg_state = 32'ha0e0_98ff;
  logic [`IQ_ROB_W-1:0] rob_next;
  int                   model_count [2];
  int                   checks;
  int                   errors;

  // bundle seen at the previous falling edge.
  logic                     snap_valid;
  logic [`IQ_EXT_COUNT-1:0] snap_slot_valid;
  logic [`IQ_EXT_COUNT-1:0] snap_stream;
  logic [`IQ_ROB_W-1:0]     snap_rob [`IQ_EXT_COUNT];
  logic [`IQ_DATA_W-1:0]    snap_result [`IQ_EXT_COUNT];

  iq_subsystem dut0 (
    .clock              (clock),
    .reset_n            (reset_n),
    .ins_enable_i       (ins_enable_i),
    .ins_count_i        (ins_count_i),
    .ins_entries_i      (ins_entries_i),
    .flush_i            (flush_i),
    .flush_stream_i     (flush_stream_i),
    .retire_ready_i     (retire_ready_i),
    .full_o             (full_o),
    .empty_o            (empty_o),
    .used_count_o       (used_count_o),
    .retire_valid_o     (retire_valid_o),
    .retire_slot_valid_o(retire_slot_valid_o),
    .retire_stream_o    (retire_stream_o),
    .retire_rob_slot_o  (retire_rob_slot_o),
    .retire_result_o    (retire_result_o),
    .retire_count_o     (retire_count_o)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // lane operation rule, wrapping at the operand width.
  function automatic logic [`IQ_DATA_W-1:0] alu_ref(input iq_entry_t e);
    case (e.op)
      op_add:  return e.operand_a + e.operand_b;
      op_sub:  return e.operand_a - e.operand_b;
      op_xor:  return e.operand_a ^ e.operand_b;
      default: return e.operand_a;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic fill_stage(input logic [`IQ_INS_COUNT-1:0] streams);
    logic [31:0] r;
    for (int i = 0; i < `IQ_INS_COUNT; i++) begin
      r                  = lcg_next();
      stage[i].stream    = streams[i];
      stage[i].rob_slot  = rob_next;
      stage[i].op        = iq_op_e'(r[31:30]);
      stage[i].operand_a = r[23:16];
      stage[i].operand_b = r[15:8];
      rob_next           = rob_next + 1'b1;
    end
  endtask

  // entries whose keep bit is low are expected to vanish.
  task automatic drive_stage(input int n, input logic [`IQ_INS_COUNT-1:0] keep);
    ins_enable_i = 1'b1;
    ins_count_i  = ($clog2(`IQ_INS_COUNT))'(n - 1);
    for (int i = 0; i < `IQ_INS_COUNT; i++) begin
      ins_entries_i[i] = stage[i];
      if (i < n && keep[i]) expect_q.push_back(stage[i]);
    end
  endtask

  // a bundle shown with ready high was taken at the edge just past.
  task automatic monitor_step();
    iq_entry_t e;
    if (snap_valid && retire_ready_i) begin
      for (int i = 0; i < `IQ_EXT_COUNT; i++) begin
        if (snap_slot_valid[i]) begin
          assert (expect_q.size() > 0) else begin
            errors++;
            $display("retire slot %0d held an instruction that was never inserted", i);
          end
          if (expect_q.size() > 0) begin
            e = expect_q.pop_front();
            check_val($sformatf("retire_stream_o[%0d]", i), e.stream, snap_stream[i]);
            check_val($sformatf("retire_rob_slot_o[%0d]", i), e.rob_slot, snap_rob[i]);
            check_val($sformatf("retire_result_o[%0d]", i), alu_ref(e), snap_result[i]);
            model_count[e.stream]++;
          end
        end
      end
    end else if (snap_valid) begin
      check_val("retire_valid_o", 1, retire_valid_o);  // stalled bundle must not move.
      check_val("retire_slot_valid_o", snap_slot_valid, retire_slot_valid_o);
      check_val("retire_stream_o", snap_stream, retire_stream_o);
      for (int i = 0; i < `IQ_EXT_COUNT; i++) begin
        check_val($sformatf("retire_rob_slot_o[%0d]", i), snap_rob[i], retire_rob_slot_o[i]);
        check_val($sformatf("retire_result_o[%0d]", i), snap_result[i], retire_result_o[i]);
      end
    end
    snap_valid      = retire_valid_o;
    snap_slot_valid = retire_slot_valid_o;
    snap_stream     = retire_stream_o;
    snap_rob        = retire_rob_slot_o;
    snap_result     = retire_result_o;
  endtask

  task automatic next_cycle();
    @(negedge clock);
    monitor_step();
    ins_enable_i = 1'b0;
  endtask

  task automatic drain_pipeline();
    int  waited;
    bit  drained;
    waited         = 0;
    retire_ready_i = 1'b1;
    drained        = (expect_q.size() == 0) && empty_o && !retire_valid_o;
    while (!drained && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
      drained = (expect_q.size() == 0) && empty_o && !retire_valid_o;
    end
    assert (drained) else begin
      errors++;
      $display("pipeline did not drain, %0d instructions never retired", expect_q.size());
    end
    check_val("retire_count_o[0]", model_count[0], retire_count_o[0]);
    check_val("retire_count_o[1]", model_count[1], retire_count_o[1]);
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic after_reset_test();
    next_cycle();
    check_val("empty_o", 1, empty_o);
    check_val("full_o", 0, full_o);
    check_val("used_count_o", 0, used_count_o);
    check_val("retire_valid_o", 0, retire_valid_o);
    check_val("retire_count_o[0]", 0, retire_count_o[0]);
    check_val("retire_count_o[1]", 0, retire_count_o[1]);
  endtask

  task automatic single_insert_test();
    iq_entry_t e;
    for (int k = 0; k < 4; k++) begin
      next_cycle();
      retire_ready_i = 1'b1;
      fill_stage(lcg_next() >> 28);
      stage[0].op = iq_op_e'(k);
      e = stage[0];
      drive_stage(1, 4'hf);
      next_cycle();
      check_val("retire_valid_o", 0, retire_valid_o);
      next_cycle();
      check_val("retire_valid_o", 0, retire_valid_o);
      next_cycle();  // third edge after the insert.
      check_val("retire_valid_o", 1, retire_valid_o);
      check_val("retire_slot_valid_o", 4'b0001, retire_slot_valid_o);
      check_val("retire_stream_o[0]", e.stream, retire_stream_o[0]);
      check_val("retire_rob_slot_o[0]", e.rob_slot, retire_rob_slot_o[0]);
      check_val("retire_result_o[0]", alu_ref(e), retire_result_o[0]);
    end
    drain_pipeline();
  endtask

  task automatic random_stream_test();
    logic [31:0] r;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      next_cycle();
      r              = lcg_next();
      retire_ready_i = (r[31:30] != 2'b00);
      if (r[29] && !full_o) begin
        fill_stage(r[26:23]);
        drive_stage(int'(r[28:27]) + 1, 4'hf);
      end
    end
    drain_pipeline();
  endtask

  task automatic full_test();
    int exp_used;
    bit lanes_m;
    bit ret_m;
    bit full_m;
    bit saw_full;
    exp_used = 0;
    lanes_m  = 1'b0;
    ret_m    = 1'b0;
    saw_full = 1'b0;
    for (int c = 0; c < 10; c++) begin
      next_cycle();
      retire_ready_i = 1'b0;
      check_val("used_count_o", exp_used, used_count_o);
      check_val("full_o", exp_used > (`IQ_DEPTH - `IQ_INS_COUNT), full_o);
      check_val("empty_o", exp_used == 0, empty_o);
      if (full_o) begin
        saw_full = 1'b1;
        break;
      end
      fill_stage(lcg_next() >> 28);
      drive_stage(4, 4'hf);
      // the stages advance only while the retire register is empty.
      full_m = exp_used > (`IQ_DEPTH - `IQ_INS_COUNT);
      if (!ret_m) begin
        ret_m    = lanes_m;
        lanes_m  = exp_used > 0;
        exp_used = exp_used - ((exp_used > 4) ? 4 : exp_used);
      end
      if (!full_m) exp_used = exp_used + 4;
    end
    assert (saw_full) else begin
      errors++;
      $display("full_o never rose while inserting against a stalled retire port");
    end
    fill_stage(lcg_next() >> 28);
    drive_stage(4, 4'h0);  // offered while full, so it is lost.
    next_cycle();
    check_val("used_count_o", exp_used, used_count_o);
    check_val("full_o", 1, full_o);
    repeat (4) next_cycle();
    drain_pipeline();
  endtask

  task automatic flush_test();
    next_cycle();
    retire_ready_i = 1'b0;
    fill_stage(4'b1010);
    drive_stage(4, 4'hf);
    next_cycle();
    fill_stage(4'b0101);
    drive_stage(4, 4'b1010);  // stream 1 results in the lanes get squashed.
    next_cycle();
    next_cycle();
    check_val("retire_valid_o", 1, retire_valid_o);
    fill_stage(4'b1011);
    drive_stage(4, 4'b1100);  // the leading stream 1 run is dropped from the queue.
    next_cycle();
    check_val("used_count_o", 4, used_count_o);
    flush_i        = 1'b1;
    flush_stream_i = 1'b1;
    next_cycle();
    check_val("used_count_o", 2, used_count_o);
    retire_ready_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    check_val("used_count_o", 0, used_count_o);
    drain_pipeline();
  endtask

  ////////////////////
  // run control
  ////////////////////

  initial begin
    #((TEST_BUDGET + MARGIN) * CLK_PERIOD);
    $display("watchdog expired before the tests finished, errors so far: %0d", errors);
    $display("sim failed");
    $finish;
  end

  initial begin
    reset_n        = 1'b0;
    ins_enable_i   = 1'b0;
    ins_count_i    = '0;
    flush_i        = 1'b0;
    flush_stream_i = 1'b0;
    retire_ready_i = 1'b0;
    for (int i = 0; i < `IQ_INS_COUNT; i++) ins_entries_i[i] = '0;
    rob_next       = '0;
    model_count[0] = 0;
    model_count[1] = 0;
    checks         = 0;
    errors         = 0;
    snap_valid     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    after_reset_test();
    single_insert_test();
    random_stream_test();
    full_test();
    flush_test();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/iq_pkg.sv
source/inst_queue.sv
source/issue_lane.sv
source/retire_collector.sv
source/iq_subsystem.sv
verification/iq_tb.sv

// ==== Bender.yml ====
package:
  name: iq_subsystem

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/iq_pkg.sv
      - source/inst_queue.sv
      - source/issue_lane.sv
      - source/retire_collector.sv
      - source/iq_subsystem.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/iq_tb.sv
